// ==== source/cpu_params.svh ====
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Memory bus
`define CPU_ADDR_WIDTH 6
`define CPU_DATA_WIDTH 16
`define CPU_MEM_WORDS 64

// Instruction word layout, opcode on top then X, Y, Z
`define CPU_OPCODE_WIDTH 4
`define CPU_FIELD_WIDTH 4

// Low field bits that form a direct address
`define CPU_DIRECT_BITS 3

// First instruction after reset
`define CPU_RESET_PC 8

// Cycles of steady pc that count as halted
`define CPU_HALT_WINDOW 40

`endif

// ==== source/cpu_pkg.sv ====
`default_nettype none
`include "cpu_params.svh"

package cpu_pkg;

    typedef logic [`CPU_ADDR_WIDTH-1:0] addr_t;
    typedef logic [`CPU_DATA_WIDTH-1:0] word_t;
    typedef logic [`CPU_FIELD_WIDTH-1:0] field_t;

    typedef enum logic [`CPU_OPCODE_WIDTH-1:0] {
        OP_MOV  = 4'b0000,
        OP_ADD  = 4'b0001,
        OP_SUB  = 4'b0010,
        OP_MUL  = 4'b0011,
        OP_IN   = 4'b0111,
        OP_OUT  = 4'b1000,
        OP_STOP = 4'b1111
    } opcode_t;

    typedef enum logic [1:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_MUL
    } alu_op_t;

    // MAR sources, raw field for pointer reads
    typedef enum logic [2:0] {
        MAR_PC,
        MAR_FX,
        MAR_FY,
        MAR_FZ,
        MAR_EAX,
        MAR_EAY,
        MAR_EAZ
    } mar_sel_t;

    typedef enum logic [1:0] {
        WB_Y,
        WB_ALU,
        WB_IN
    } wb_sel_t;

    typedef enum logic [1:0] {
        SLOT_X,
        SLOT_Y,
        SLOT_Z
    } operand_t;

    typedef enum logic [4:0] {
        S_FETCH,
        S_FETCH_RD,
        S_FETCH_IR,
        S_DECODE,
        S_EA,
        S_EA_RD,
        S_EA_PTR,
        S_DISPATCH,
        S_RD,
        S_RD_MEM,
        S_RD_USE,
        S_MOV_WB,
        S_ALU_EXEC,
        S_ALU_WB,
        S_IN_WAIT,
        S_STOP_NEXT,
        S_HALT
    } seq_state_t;

endpackage

`default_nettype wire

// ==== source/cpu_alu.sv ====
`default_nettype none
`include "cpu_params.svh"

module cpu_alu
    import cpu_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    rst_n,
    input  wire logic    alu_start,
    input  wire alu_op_t alu_op,
    input  wire word_t   y_val,
    input  wire word_t   z_val,
    output word_t        result
);

    alu_op_t op_q;
    word_t   a_q;
    word_t   b_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            op_q <= ALU_ADD;
        end else if (alu_start) begin
            op_q <= alu_op;
        end
    end

    always_ff @(posedge clk) begin
        if (alu_start) begin
            a_q <= y_val;
            b_q <= z_val;
        end
    end

    // All results wrap modulo 2^16
    always_comb begin
        case (op_q)
            ALU_SUB: result = a_q - b_q;
            ALU_MUL: result = a_q * b_q;
            default: result = a_q + b_q;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/cpu_datapath.sv ====
`default_nettype none
`include "cpu_params.svh"

module cpu_datapath
    import cpu_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst_n,
    input  wire word_t    mem,
    input  wire word_t    in,
    input  wire logic     mar_ld,
    input  wire logic     mdr_ld,
    input  wire logic     ir_ld,
    input  wire logic     pc_inc,
    input  wire logic     ea_ld,
    input  wire logic     ea_from_mdr,
    input  wire logic     y_ld,
    input  wire logic     z_ld,
    input  wire logic     out_ld,
    input  wire logic     wb_ld,
    input  wire mar_sel_t mar_sel,
    input  wire operand_t ea_slot,
    input  wire wb_sel_t  wb_sel,
    input  wire word_t    result,
    output opcode_t       opcode,
    output field_t        field_x,
    output field_t        field_y,
    output field_t        field_z,
    output word_t         y_val,
    output word_t         z_val,
    output addr_t         addr,
    output addr_t         pc,
    output word_t         data,
    output word_t         out,
    output logic          we
);

    word_t  ir;
    word_t  mdr;
    addr_t  ea_x;
    addr_t  ea_y;
    addr_t  ea_z;
    addr_t  mar_next;
    addr_t  ea_next;
    field_t slot_field;
    word_t  wb_word;

    function automatic addr_t field_addr(input field_t f);
        return addr_t'(f[`CPU_DIRECT_BITS-1:0]);
    endfunction

    assign opcode  = opcode_t'(ir[`CPU_DATA_WIDTH-1 -: `CPU_OPCODE_WIDTH]);
    assign field_x = ir[3*`CPU_FIELD_WIDTH-1 -: `CPU_FIELD_WIDTH];
    assign field_y = ir[2*`CPU_FIELD_WIDTH-1 -: `CPU_FIELD_WIDTH];
    assign field_z = ir[`CPU_FIELD_WIDTH-1:0];

    always_comb begin
        case (mar_sel)
            MAR_FX:  mar_next = field_addr(field_x);
            MAR_FY:  mar_next = field_addr(field_y);
            MAR_FZ:  mar_next = field_addr(field_z);
            MAR_EAX: mar_next = ea_x;
            MAR_EAY: mar_next = ea_y;
            MAR_EAZ: mar_next = ea_z;
            default: mar_next = pc;
        endcase
    end

    // Effective address from the field itself or from the fetched pointer
    always_comb begin
        case (ea_slot)
            SLOT_X:  slot_field = field_x;
            SLOT_Y:  slot_field = field_y;
            default: slot_field = field_z;
        endcase
        ea_next = ea_from_mdr ? mdr[`CPU_ADDR_WIDTH-1:0] : field_addr(slot_field);
    end

    always_comb begin
        case (wb_sel)
            WB_ALU:  wb_word = result;
            WB_IN:   wb_word = in;
            default: wb_word = y_val;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc   <= addr_t'(`CPU_RESET_PC);
            addr <= '0;
            out  <= '0;
            we   <= 1'b0;
        end else begin
            if (pc_inc) pc <= pc + 1'b1;
            if (mar_ld) addr <= mar_next;
            if (out_ld) out <= mdr;
            we <= wb_ld;
        end
    end

    always_ff @(posedge clk) begin
        if (mdr_ld) mdr <= mem;
        if (ir_ld) ir <= mdr;
        if (y_ld) y_val <= mdr;
        if (z_ld) z_val <= mdr;
        if (wb_ld) data <= wb_word;
        if (ea_ld) begin
            case (ea_slot)
                SLOT_X:  ea_x <= ea_next;
                SLOT_Y:  ea_y <= ea_next;
                default: ea_z <= ea_next;
            endcase
        end
    end

    a_mar_sel_legal: assert property (@(posedge clk) disable iff (!rst_n)
        mar_ld |-> mar_sel inside {MAR_PC, MAR_FX, MAR_FY, MAR_FZ, MAR_EAX, MAR_EAY, MAR_EAZ});

endmodule

`default_nettype wire

// ==== source/cpu_sequencer.sv ====
`default_nettype none
`include "cpu_params.svh"

module cpu_sequencer
    import cpu_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    rst_n,
    input  wire opcode_t opcode,
    input  wire field_t  field_x,
    input  wire field_t  field_y,
    input  wire field_t  field_z,
    input  wire logic    control,
    output logic         status,
    output logic         mar_ld,
    output logic         mdr_ld,
    output logic         ir_ld,
    output logic         pc_inc,
    output logic         ea_ld,
    output logic         ea_from_mdr,
    output logic         y_ld,
    output logic         z_ld,
    output logic         out_ld,
    output logic         wb_ld,
    output logic         alu_start,
    output mar_sel_t     mar_sel,
    output operand_t     ea_slot,
    output wb_sel_t      wb_sel,
    output alu_op_t      alu_op
);

    seq_state_t state_q;
    seq_state_t state_d;
    operand_t   slot_q;
    operand_t   slot_d;
    operand_t   slot_next;
    operand_t   last_slot;
    field_t     cur_field;
    mar_sel_t   field_sel;
    mar_sel_t   ea_sel;
    logic       ea_last;
    logic       legal_op;

    assign legal_op = opcode inside {OP_MOV, OP_ADD, OP_SUB, OP_MUL, OP_IN, OP_OUT, OP_STOP};
    assign ea_slot = slot_q;
    assign slot_next = operand_t'(slot_q + 2'd1);
    assign ea_last = (slot_q == last_slot);

    // Last operand whose address the opcode needs
    always_comb begin
        case (opcode)
            OP_IN, OP_OUT: last_slot = SLOT_X;
            OP_MOV:        last_slot = SLOT_Y;
            default:       last_slot = SLOT_Z;
        endcase
    end

    always_comb begin
        case (opcode)
            OP_SUB:  alu_op = ALU_SUB;
            OP_MUL:  alu_op = ALU_MUL;
            default: alu_op = ALU_ADD;
        endcase
    end

    always_comb begin
        case (slot_q)
            SLOT_X: begin
                cur_field = field_x;
                field_sel = MAR_FX;
                ea_sel    = MAR_EAX;
            end
            SLOT_Y: begin
                cur_field = field_y;
                field_sel = MAR_FY;
                ea_sel    = MAR_EAY;
            end
            default: begin
                cur_field = field_z;
                field_sel = MAR_FZ;
                ea_sel    = MAR_EAZ;
            end
        endcase
    end

    always_comb begin
        state_d     = state_q;
        slot_d      = slot_q;
        mar_ld      = 1'b0;
        mar_sel     = MAR_PC;
        mdr_ld      = 1'b0;
        ir_ld       = 1'b0;
        pc_inc      = 1'b0;
        ea_ld       = 1'b0;
        ea_from_mdr = 1'b0;
        y_ld        = 1'b0;
        z_ld        = 1'b0;
        out_ld      = 1'b0;
        wb_ld       = 1'b0;
        wb_sel      = WB_Y;
        alu_start   = 1'b0;

        case (state_q)
            S_FETCH: begin
                mar_ld  = 1'b1;
                mar_sel = MAR_PC;
                state_d = S_FETCH_RD;
            end
            S_FETCH_RD: begin
                mdr_ld  = 1'b1;
                state_d = S_FETCH_IR;
            end
            S_FETCH_IR: begin
                ir_ld   = 1'b1;
                pc_inc  = 1'b1;
                state_d = S_DECODE;
            end
            S_DECODE: begin
                slot_d  = SLOT_X;
                state_d = legal_op ? S_EA : S_HALT;
            end
            S_EA: begin
                if (cur_field[`CPU_FIELD_WIDTH-1]) begin
                    // Pointer word lives at the field address
                    mar_ld  = 1'b1;
                    mar_sel = field_sel;
                    state_d = S_EA_RD;
                end else begin
                    // A zero field lands on address 0
                    ea_ld   = 1'b1;
                    slot_d  = ea_last ? slot_q : slot_next;
                    state_d = ea_last ? S_DISPATCH : S_EA;
                end
            end
            S_EA_RD: begin
                mdr_ld  = 1'b1;
                state_d = S_EA_PTR;
            end
            S_EA_PTR: begin
                ea_ld       = 1'b1;
                ea_from_mdr = 1'b1;
                slot_d      = ea_last ? slot_q : slot_next;
                state_d     = ea_last ? S_DISPATCH : S_EA;
            end
            S_DISPATCH: begin
                case (opcode)
                    OP_IN: begin
                        state_d = S_IN_WAIT;
                    end
                    OP_STOP: begin
                        slot_d  = SLOT_X;
                        state_d = S_STOP_NEXT;
                    end
                    OP_OUT: begin
                        slot_d  = SLOT_X;
                        state_d = S_RD;
                    end
                    default: begin
                        // MOV and the ALU ops read Y first
                        slot_d  = SLOT_Y;
                        state_d = S_RD;
                    end
                endcase
            end
            S_RD: begin
                mar_ld  = 1'b1;
                mar_sel = ea_sel;
                state_d = S_RD_MEM;
            end
            S_RD_MEM: begin
                mdr_ld  = 1'b1;
                state_d = S_RD_USE;
            end
            S_RD_USE: begin
                case (opcode)
                    OP_OUT: begin
                        out_ld  = 1'b1;
                        state_d = S_FETCH;
                    end
                    OP_STOP: begin
                        out_ld  = 1'b1;
                        slot_d  = slot_next;
                        state_d = (slot_q == SLOT_Z) ? S_HALT : S_STOP_NEXT;
                    end
                    OP_MOV: begin
                        y_ld    = 1'b1;
                        state_d = S_MOV_WB;
                    end
                    default: begin
                        if (slot_q == SLOT_Y) begin
                            y_ld    = 1'b1;
                            slot_d  = SLOT_Z;
                            state_d = S_RD;
                        end else begin
                            z_ld    = 1'b1;
                            state_d = S_ALU_EXEC;
                        end
                    end
                endcase
            end
            S_MOV_WB: begin
                wb_ld   = 1'b1;
                wb_sel  = WB_Y;
                mar_ld  = 1'b1;
                mar_sel = MAR_EAX;
                state_d = S_FETCH;
            end
            S_ALU_EXEC: begin
                alu_start = 1'b1;
                state_d   = S_ALU_WB;
            end
            S_ALU_WB: begin
                wb_ld   = 1'b1;
                wb_sel  = WB_ALU;
                mar_ld  = 1'b1;
                mar_sel = MAR_EAX;
                state_d = S_FETCH;
            end
            S_IN_WAIT: begin
                if (control) begin
                    wb_ld   = 1'b1;
                    wb_sel  = WB_IN;
                    mar_ld  = 1'b1;
                    mar_sel = MAR_EAX;
                    state_d = S_FETCH;
                end
            end
            S_STOP_NEXT: begin
                if (cur_field == '0) begin
                    slot_d  = slot_next;
                    state_d = (slot_q == SLOT_Z) ? S_HALT : S_STOP_NEXT;
                end else begin
                    state_d = S_RD;
                end
            end
            S_HALT: begin
                state_d = S_HALT;
            end
            default: begin
                state_d = S_HALT;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= S_FETCH;
            slot_q  <= SLOT_X;
            status  <= 1'b0;
        end else begin
            state_q <= state_d;
            slot_q  <= slot_d;
            status  <= (state_d == S_IN_WAIT);
        end
    end

    // Halt follows STOP or an illegal opcode and never writes
    a_halt_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        state_q == S_HALT |=> state_q == S_HALT && !wb_ld
            && (opcode == OP_STOP || !legal_op));

    // Only an IN instruction waits
    a_status_in_wait: assert property (@(posedge clk) disable iff (!rst_n)
        status |-> opcode == OP_IN);

endmodule

`default_nettype wire

// ==== source/cpu_top.sv ====
`default_nettype none
`include "cpu_params.svh"

module cpu_top
    import cpu_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  rst_n,
    input  wire word_t mem,
    input  wire word_t in,
    input  wire logic  control,
    output logic       status,
    output logic       we,
    output addr_t      addr,
    output word_t      data,
    output word_t      out,
    output addr_t      pc
);

    opcode_t  opcode;
    field_t   field_x;
    field_t   field_y;
    field_t   field_z;
    logic     mar_ld;
    logic     mdr_ld;
    logic     ir_ld;
    logic     pc_inc;
    logic     ea_ld;
    logic     ea_from_mdr;
    logic     y_ld;
    logic     z_ld;
    logic     out_ld;
    logic     wb_ld;
    logic     alu_start;
    mar_sel_t mar_sel;
    operand_t ea_slot;
    wb_sel_t  wb_sel;
    alu_op_t  alu_op;
    word_t    y_val;
    word_t    z_val;
    word_t    result;

    cpu_sequencer u_sequencer (
        .clk         (clk),
        .rst_n       (rst_n),
        .opcode      (opcode),
        .field_x     (field_x),
        .field_y     (field_y),
        .field_z     (field_z),
        .control     (control),
        .status      (status),
        .mar_ld      (mar_ld),
        .mdr_ld      (mdr_ld),
        .ir_ld       (ir_ld),
        .pc_inc      (pc_inc),
        .ea_ld       (ea_ld),
        .ea_from_mdr (ea_from_mdr),
        .y_ld        (y_ld),
        .z_ld        (z_ld),
        .out_ld      (out_ld),
        .wb_ld       (wb_ld),
        .alu_start   (alu_start),
        .mar_sel     (mar_sel),
        .ea_slot     (ea_slot),
        .wb_sel      (wb_sel),
        .alu_op      (alu_op)
    );

    cpu_datapath u_datapath (
        .clk         (clk),
        .rst_n       (rst_n),
        .mem         (mem),
        .in          (in),
        .mar_ld      (mar_ld),
        .mdr_ld      (mdr_ld),
        .ir_ld       (ir_ld),
        .pc_inc      (pc_inc),
        .ea_ld       (ea_ld),
        .ea_from_mdr (ea_from_mdr),
        .y_ld        (y_ld),
        .z_ld        (z_ld),
        .out_ld      (out_ld),
        .wb_ld       (wb_ld),
        .mar_sel     (mar_sel),
        .ea_slot     (ea_slot),
        .wb_sel      (wb_sel),
        .result      (result),
        .opcode      (opcode),
        .field_x     (field_x),
        .field_y     (field_y),
        .field_z     (field_z),
        .y_val       (y_val),
        .z_val       (z_val),
        .addr        (addr),
        .pc          (pc),
        .data        (data),
        .out         (out),
        .we          (we)
    );

    cpu_alu u_alu (
        .clk       (clk),
        .rst_n     (rst_n),
        .alu_start (alu_start),
        .alu_op    (alu_op),
        .y_val     (y_val),
        .z_val     (z_val),
        .result    (result)
    );

endmodule

`default_nettype wire

// ==== testbench/cpu_tb_programs.svh ====
`ifndef CPU_TB_PROGRAMS_SVH
`define CPU_TB_PROGRAMS_SVH

localparam int NUM_TESTS = 6;
localparam int NUM_ROWS  = 62;

localparam logic [3:0] ROW_INIT  = 4'h1;
localparam logic [3:0] ROW_WRITE = 4'h2;
localparam logic [3:0] ROW_OUT   = 4'h3;
localparam logic [3:0] ROW_IN    = 4'h4;
localparam logic [3:0] ROW_PC    = 4'h5;

string test_names [NUM_TESTS] = '{"mov", "alu", "out", "in", "stop", "div_halt"};

// Columns: kind _ test _ address or index _ value
// Kinds: 1 initial word, 2 expected write, 3 out value, 4 word for the next IN, 5 final pc
localparam logic [31:0] TEST_ROWS [NUM_ROWS] = '{
    // MOV direct, pointer to pointer, direct from pointer
    32'h1_0_01_1234, 32'h1_0_02_0020, 32'h1_0_03_0021, 32'h1_0_21_beef,
    32'h1_0_08_0410, 32'h1_0_09_0ab0, 32'h1_0_0a_05b0, 32'h1_0_0b_f000,
    32'h2_0_04_1234, 32'h2_0_20_beef, 32'h2_0_05_beef,
    32'h5_0_00_000c,
    // ADD wraps, SUB borrows, MUL keeps the low half, Z zero reads address 0
    32'h1_1_00_0007, 32'h1_1_01_fff0, 32'h1_1_02_0025, 32'h1_1_03_0100,
    32'h1_1_04_0301, 32'h1_1_08_1512, 32'h1_1_09_2623, 32'h1_1_0a_3734,
    32'h1_1_0b_1320, 32'h1_1_0c_f000,
    32'h2_1_05_0015, 32'h2_1_06_ff25, 32'h2_1_07_0100, 32'h2_1_03_002c,
    32'h5_1_00_000d,
    // OUT direct and indirect, then STOP with only Y set
    32'h1_2_05_0a5a, 32'h1_2_06_0030, 32'h1_2_30_1357, 32'h1_2_07_7e7e,
    32'h1_2_08_8500, 32'h1_2_09_8e00, 32'h1_2_0a_f070,
    32'h3_2_00_0a5a, 32'h3_2_01_1357, 32'h3_2_02_7e7e,
    32'h5_2_00_000b,
    // Two IN waits, the second through a pointer
    32'h1_3_03_0028, 32'h1_3_08_7200, 32'h1_3_09_7b00, 32'h1_3_0a_f000,
    32'h2_3_02_c0de, 32'h2_3_28_0f1e,
    32'h4_3_00_c0de, 32'h4_3_01_0f1e,
    32'h5_3_00_000b,
    // STOP dumps X, Y and an indirect Z
    32'h1_4_01_2468, 32'h1_4_02_0033, 32'h1_4_03_5a5a, 32'h1_4_33_9bdf,
    32'h1_4_08_f13a,
    32'h3_4_00_2468, 32'h3_4_01_5a5a, 32'h3_4_02_9bdf,
    32'h5_4_00_0009,
    // DIV halts, the MOV after it never runs
    32'h1_5_01_1111, 32'h1_5_08_0410, 32'h1_5_09_4512, 32'h1_5_0a_0610,
    32'h2_5_04_1111,
    32'h5_5_00_000a
};

`endif

// ==== testbench/cpu_tb.sv ====
`default_nettype none
`include "cpu_params.svh"

module cpu_tb
    import cpu_pkg::*;
();

    localparam int INSTR_BUDGET = 40;
    localparam int IN_BUDGET    = 16;

    logic   clk;
    logic   rst_n;
    word_t  mem;
    word_t  in;
    logic   control;
    logic   status;
    logic   we;
    addr_t  addr;
    word_t  data;
    word_t  out;
    addr_t  pc;

    `include "cpu_tb_programs.svh"

    word_t  mem_model [`CPU_MEM_WORDS];
    word_t  exp_mem [`CPU_MEM_WORDS];
    word_t  exp_out [$];
    word_t  seen_out [$];
    word_t  in_words [$];
    addr_t  exp_pc;
    word_t  last_out;
    string  cur_name;
    int     exp_writes;
    int     writes_seen;
    int     errors;
    int     pass_count;
    int     fail_count;
    int     in_idx;
    int     in_delay;
    int     in_wait_count;
    logic   in_waiting;
    logic   timed_out;
    integer seed;

    cpu_top u_dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .mem     (mem),
        .in      (in),
        .control (control),
        .status  (status),
        .we      (we),
        .addr    (addr),
        .data    (data),
        .out     (out),
        .pc      (pc)
    );

    // Asynchronous read, like the external memory
    assign mem = mem_model[addr];

    initial clk = 1'b0;

    always #10 clk = ~clk;

    // Unused words decode as DIV and differ at every address
    function automatic word_t fill_word(input addr_t a);
        return {4'h4, a, a};
    endfunction

    task automatic load_test(input int t);
        logic [3:0] kind;
        addr_t      a;
        word_t      v;
        exp_out.delete();
        in_words.delete();
        exp_writes = 0;
        exp_pc     = addr_t'(`CPU_RESET_PC);
        for (int i = 0; i < `CPU_MEM_WORDS; i++) begin
            mem_model[i] = fill_word(addr_t'(i));
            exp_mem[i]   = mem_model[i];
        end
        for (int r = 0; r < NUM_ROWS; r++) begin
            if (TEST_ROWS[r][27:24] == 4'(t)) begin
                kind = TEST_ROWS[r][31:28];
                a    = TEST_ROWS[r][16 +: `CPU_ADDR_WIDTH];
                v    = TEST_ROWS[r][15:0];
                case (kind)
                    ROW_INIT: begin
                        mem_model[a] = v;
                        exp_mem[a]   = v;
                    end
                    ROW_WRITE: begin
                        exp_mem[a] = v;
                        exp_writes++;
                    end
                    ROW_OUT: exp_out.push_back(v);
                    ROW_IN:  in_words.push_back(v);
                    ROW_PC:  exp_pc = v[`CPU_ADDR_WIDTH-1:0];
                    default: ;
                endcase
            end
        end
    endtask

    // One clock of the memory model, out monitor and IN handshake
    task automatic step_cycle();
        @(negedge clk);
        if (we) begin
            mem_model[addr] = data;
            writes_seen++;
        end
        if (out !== last_out) begin
            seen_out.push_back(out);
            last_out = out;
        end
        if (status && !in_waiting) begin
            in_waiting    = 1'b1;
            in_wait_count = 0;
            in_delay      = $random(seed) & 32'hf;
            if (in_idx < in_words.size()) begin
                in = in_words[in_idx];
            end else begin
                in = '0;
            end
        end
        if (in_waiting) begin
            if (!status) begin
                if (!control) begin
                    $display("%s: status fell before control was raised", cur_name);
                    errors++;
                end
                in_waiting = 1'b0;
                control    = 1'b0;
                in_idx++;
            end else if (in_wait_count == in_delay) begin
                control = 1'b1;
            end else begin
                in_wait_count++;
            end
        end
    endtask

    task automatic check_results();
        if (pc !== exp_pc) begin
            $display("ERROR %s: pc expected %h actual %h", cur_name, exp_pc, pc);
            errors++;
        end
        if (writes_seen != exp_writes) begin
            $display("ERROR %s: write count expected %0d actual %0d",
                     cur_name, exp_writes, writes_seen);
            errors++;
        end
        if (seen_out.size() != exp_out.size()) begin
            $display("ERROR %s: out count expected %0d actual %0d",
                     cur_name, exp_out.size(), seen_out.size());
            errors++;
        end else begin
            for (int i = 0; i < exp_out.size(); i++) begin
                if (seen_out[i] !== exp_out[i]) begin
                    $display("ERROR %s: out[%0d] expected %h actual %h",
                             cur_name, i, exp_out[i], seen_out[i]);
                    errors++;
                end
            end
        end
        for (int a = 0; a < `CPU_MEM_WORDS; a++) begin
            if (mem_model[a] !== exp_mem[a]) begin
                $display("ERROR %s: mem[%0h] expected %h actual %h",
                         cur_name, a, exp_mem[a], mem_model[a]);
                errors++;
            end
        end
    endtask

    task automatic execute_test(input int t);
        int    cycles;
        int    steady;
        int    limit;
        addr_t last_pc;
        cur_name    = test_names[t];
        errors      = 0;
        writes_seen = 0;
        in_idx      = 0;
        in_waiting  = 1'b0;
        control     = 1'b0;
        in          = '0;
        rst_n       = 1'b0;
        seen_out.delete();
        load_test(t);
        repeat (4) @(negedge clk);
        if (pc !== addr_t'(`CPU_RESET_PC) || we !== 1'b0 || status !== 1'b0 || out !== '0) begin
            $display("%s: outputs are not at their reset values during reset", cur_name);
            errors++;
        end
        rst_n    = 1'b1;
        last_out = out;
        limit    = (int'(exp_pc) - `CPU_RESET_PC) * INSTR_BUDGET
                   + in_words.size() * IN_BUDGET + `CPU_HALT_WINDOW;
        cycles   = 0;
        steady   = 0;
        last_pc  = pc;
        // Halted once pc holds still outside an IN wait
        while (steady < `CPU_HALT_WINDOW && cycles < limit) begin
            step_cycle();
            cycles++;
            if (pc == last_pc && !status) begin
                steady++;
            end else begin
                steady = 0;
            end
            last_pc = pc;
        end
        if (steady < `CPU_HALT_WINDOW) begin
            $display("%s: core did not halt within %0d cycles", cur_name, limit);
            errors++;
            timed_out = 1'b1;
        end else begin
            check_results();
        end
        if (errors == 0) begin
            $display("PASS %s", cur_name);
            pass_count++;
        end else begin
            $display("FAIL %s with %0d errors", cur_name, errors);
            fail_count++;
        end
    endtask

    initial begin
        seed       = 32'hb93c;
        rst_n      = 1'b0;
        control    = 1'b0;
        in         = '0;
        pass_count = 0;
        fail_count = 0;
        timed_out  = 1'b0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            execute_test(t);
            if (timed_out) begin
                break;
            end
        end
        $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== cpu_top.f ====
+incdir+source
+incdir+testbench
source/cpu_pkg.sv
source/cpu_alu.sv
source/cpu_datapath.sv
source/cpu_sequencer.sv
source/cpu_top.sv
testbench/cpu_tb.sv

// ==== Makefile ====
# Verilator flow for the cpu_top project

VERILATOR  ?= verilator
FILELIST   ?= cpu_top.f
RTL_TOP    ?= cpu_top
TB_TOP     ?= cpu_tb
OBJ_DIR    ?= obj_dir
LINT_FLAGS ?= --lint-only -Wall --timing
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal
PASS_MSG   ?= Testbench passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

# The run passes only if the pass message shows up in the output
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@result="$$(./$(OBJ_DIR)/V$(TB_TOP))"; \
	echo "$$result"; \
	echo "$$result" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
